// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int words_per_line = 16;
    localparam int num_ways = 2;
    localparam int num_sets = 128;
    localparam int bytes_per_word = 4;

    localparam int offset_bits = $clog2(words_per_line);
    localparam int index_bits = $clog2(num_sets);
    localparam int align_bits = $clog2(bytes_per_word);
    localparam int tag_bits = 32 - index_bits - offset_bits - align_bits;
    localparam int way_bits = $clog2(num_ways);

    // word address into the data array
    localparam int ram_addr_bits = way_bits + index_bits + offset_bits;

    // every memory burst moves one full line, one word per beat
    localparam int burst_beats = words_per_line;

    typedef logic [8*bytes_per_word-1:0] word_t;
    typedef logic [bytes_per_word-1:0] strobe_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0] way_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] align;
    } addr_t;

    // strobe of zero is a read
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } dreq_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dresp_t;

    typedef struct packed {
        logic  valid;
        logic  is_write;
        addr_t addr;
        word_t data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef struct packed {
        way_t   way;
        index_t index;
    } line_loc_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_VICTIM,
        WRITEBACK,
        FETCH
    } miss_state_t;

endpackage

// ==== dcache/dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  dreq_t req,
    input  logic  fill_en,
    input  way_t  fill_way,
    output logic  hit,
    output way_t  hit_way,
    output way_t  victim_way,
    output tag_t  victim_tag,
    output logic  victim_dirty_valid
);

    tag_t [num_ways-1:0] tag_ram [num_sets];

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [num_sets-1:0][num_ways-1:0] dirty_q;

    // way touched last in each set
    way_t [num_sets-1:0] lru_q;

    index_t              idx;
    tag_t [num_ways-1:0] set_tags;
    logic [num_ways-1:0] match;
    logic                access;

    assign idx = req.addr.index;
    assign set_tags = tag_ram[idx];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid_q[idx][w] && (set_tags[w] == req.addr.tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // victim is the way not used last
    assign victim_way = ~lru_q[idx];
    assign victim_tag = set_tags[victim_way];
    assign victim_dirty_valid = valid_q[idx][victim_way] && dirty_q[idx][victim_way];

    assign access = req.valid && hit;

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            if (access) begin
                lru_q[idx] <= hit_way;
                if (|req.strobe) begin
                    dirty_q[idx][hit_way] <= 1'b1;
                end
            end
            // new line comes in clean
            if (fill_en) begin
                valid_q[idx][fill_way] <= 1'b1;
                dirty_q[idx][fill_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_ram[idx][fill_way] <= req.addr.tag;
        end
    end

    // refill runs only while the held request misses
    fill_without_hit: assert property (
        @(posedge clk) disable iff (resetn)
        !(fill_en && hit)
    );

endmodule

// ==== dcache/dcache_data_ram.sv ====
`timescale 1ns/1ps

module dcache_data_ram import dcache_pkg::*; (
    input  logic      clk,
    input  logic      a_en,
    input  line_loc_t a_loc,
    input  offset_t   a_offset,
    input  strobe_t   a_strobe,
    input  word_t     a_wdata,
    output word_t     a_rdata,
    input  logic      b_en,
    input  line_loc_t b_loc,
    input  offset_t   b_offset,
    input  strobe_t   b_strobe,
    input  word_t     b_wdata,
    output word_t     b_rdata
);

    word_t mem [2**ram_addr_bits];

    logic [ram_addr_bits-1:0] a_addr;
    logic [ram_addr_bits-1:0] b_addr;

    assign a_addr = {a_loc, a_offset};
    assign b_addr = {b_loc, b_offset};

    // registered reads, byte lanes written per strobe
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            for (int i = 0; i < bytes_per_word; i++) begin
                if (a_strobe[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
            for (int i = 0; i < bytes_per_word; i++) begin
                if (b_strobe[i]) begin
                    mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== dcache/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps

module dcache_miss_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  dreq_t       req,
    input  logic        hit,
    input  way_t        victim_way,
    input  logic        victim_dirty_valid,
    input  cbus_resp_t  cbus_resp,
    output miss_state_t state,
    output logic        fill_en,
    output way_t        fill_way,
    output logic        b_en,
    output line_loc_t   b_loc,
    output offset_t     b_offset,
    output strobe_t     b_strobe,
    output logic        capture_en,
    output offset_t     capture_offset,
    output offset_t     beat_offset
);

    line_loc_t            victim_loc_q;
    logic [offset_bits:0] read_cnt_q;
    offset_t              beat_cnt_q;
    logic                 miss;
    logic                 reading;
    logic                 beat;
    logic                 last_beat;

    assign miss = (state == IDLE) && req.valid && !hit;

    // 16 victim reads, then one more cycle for the last word to land
    assign reading = (state == READ_VICTIM)
                   && (read_cnt_q != (offset_bits + 1)'(burst_beats));

    assign beat = cbus_resp.ready;
    assign last_beat = cbus_resp.ready && cbus_resp.last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            read_cnt_q <= '0;
            beat_cnt_q <= '0;
            capture_en <= 1'b0;
        end else begin
            capture_en <= reading;
            unique case (state)
                IDLE: begin
                    read_cnt_q <= '0;
                    beat_cnt_q <= '0;
                    if (miss) begin
                        state <= victim_dirty_valid ? READ_VICTIM : FETCH;
                    end
                end
                READ_VICTIM: begin
                    if (reading) begin
                        read_cnt_q <= read_cnt_q + 1'b1;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (last_beat) begin
                        state <= FETCH;
                        beat_cnt_q <= '0;
                    end else if (beat) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                end
                FETCH: begin
                    if (beat) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        capture_offset <= read_cnt_q[offset_bits-1:0];
        if (miss) begin
            victim_loc_q <= '{way: victim_way, index: req.addr.index};
        end
    end

    // port b reads the victim, then takes each fetched word
    assign b_en = reading || ((state == FETCH) && beat);
    assign b_loc = victim_loc_q;
    assign b_offset = (state == FETCH) ? beat_cnt_q : read_cnt_q[offset_bits-1:0];
    assign b_strobe = (state == FETCH) ? '1 : '0;

    assign fill_en = (state == FETCH) && last_beat;
    assign fill_way = victim_loc_q.way;
    assign beat_offset = beat_cnt_q;

    // fetch leaves on last, which must land on the final word of the line
    fetch_ends_on_last: assert property (
        @(posedge clk) disable iff (resetn)
        (state == FETCH) && beat |-> (last_beat == (beat_cnt_q == offset_t'(burst_beats - 1)))
    );

endmodule

// ==== src/cbus_port.sv ====
`timescale 1ns/1ps

module cbus_port import dcache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  miss_state_t state,
    input  dreq_t       req,
    input  tag_t        victim_tag,
    input  logic        capture_en,
    input  offset_t     capture_offset,
    input  offset_t     beat_offset,
    input  word_t       b_rdata,
    output cbus_req_t   cbus_req
);

    // victim line held for the write burst
    word_t line_buf [words_per_line];

    logic [words_per_line-1:0] filled_q;
    logic                      buf_full;
    addr_t                     burst_addr;

    always_ff @(posedge clk) begin
        if (capture_en) begin
            line_buf[capture_offset] <= b_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            filled_q <= '0;
        end else if (state == IDLE) begin
            filled_q <= '0;
        end else if (capture_en) begin
            filled_q[capture_offset] <= 1'b1;
        end
    end

    assign buf_full = &filled_q;

    // line aligned, old tag on writeback and request tag on refill
    always_comb begin
        burst_addr = '0;
        burst_addr.tag = (state == WRITEBACK) ? victim_tag : req.addr.tag;
        burst_addr.index = req.addr.index;
    end

    always_comb begin
        cbus_req.valid = (state == FETCH) || ((state == WRITEBACK) && buf_full);
        cbus_req.is_write = (state == WRITEBACK);
        cbus_req.addr = burst_addr;
        cbus_req.data = line_buf[beat_offset];
    end

    // the victim reads finish before the write burst begins
    writeback_buffer_full: assert property (
        @(posedge clk) disable iff (resetn)
        (state == WRITEBACK) |-> buf_full
    );

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  dreq_t      dreq,
    output dresp_t     dresp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    logic        hit;
    way_t        hit_way;
    way_t        victim_way;
    tag_t        victim_tag;
    logic        victim_dirty_valid;
    logic        fill_en;
    way_t        fill_way;
    miss_state_t state;

    logic        b_en;
    line_loc_t   b_loc;
    offset_t     b_offset;
    strobe_t     b_strobe;
    word_t       b_rdata;
    word_t       a_rdata;

    logic        capture_en;
    offset_t     capture_offset;
    offset_t     beat_offset;

    logic        addr_ok;
    logic        data_ok_q;
    line_loc_t   hit_loc;

    // a request is taken only on a hit while no miss is in flight
    assign addr_ok = dreq.valid && hit && (state == IDLE);
    assign hit_loc = '{way: hit_way, index: dreq.addr.index};

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= addr_ok;
        end
    end

    assign dresp = '{addr_ok: addr_ok, data_ok: data_ok_q, data: a_rdata};

    dcache_lookup u_lookup (
        .clk                (clk),
        .resetn             (resetn),
        .req                (dreq),
        .fill_en            (fill_en),
        .fill_way           (fill_way),
        .hit                (hit),
        .hit_way            (hit_way),
        .victim_way         (victim_way),
        .victim_tag         (victim_tag),
        .victim_dirty_valid (victim_dirty_valid)
    );

    dcache_data_ram u_data_ram (
        .clk      (clk),
        .a_en     (addr_ok),
        .a_loc    (hit_loc),
        .a_offset (dreq.addr.offset),
        .a_strobe (dreq.strobe),
        .a_wdata  (dreq.data),
        .a_rdata  (a_rdata),
        .b_en     (b_en),
        .b_loc    (b_loc),
        .b_offset (b_offset),
        .b_strobe (b_strobe),
        .b_wdata  (cbus_resp.data),
        .b_rdata  (b_rdata)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk                (clk),
        .resetn             (resetn),
        .req                (dreq),
        .hit                (hit),
        .victim_way         (victim_way),
        .victim_dirty_valid (victim_dirty_valid),
        .cbus_resp          (cbus_resp),
        .state              (state),
        .fill_en            (fill_en),
        .fill_way           (fill_way),
        .b_en               (b_en),
        .b_loc              (b_loc),
        .b_offset           (b_offset),
        .b_strobe           (b_strobe),
        .capture_en         (capture_en),
        .capture_offset     (capture_offset),
        .beat_offset        (beat_offset)
    );

    cbus_port u_cbus_port (
        .clk            (clk),
        .resetn         (resetn),
        .state          (state),
        .req            (dreq),
        .victim_tag     (victim_tag),
        .capture_en     (capture_en),
        .capture_offset (capture_offset),
        .beat_offset    (beat_offset),
        .b_rdata        (b_rdata),
        .cbus_req       (cbus_req)
    );

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  cbus_req_t  cbus_req,
    output cbus_resp_t cbus_resp
);

    localparam int mem_words = 65536;
    localparam logic [15:0] seed = 16'd15;

    word_t mem [mem_words];

    offset_t     beat_q;
    logic        stall_q;
    logic [15:0] lfsr_q;
    logic [15:0] lfsr_mid;
    logic [31:0] req_addr;
    logic [15:0] word_idx;
    logic        ready;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    function automatic word_t init_word(input logic [15:0] w);
        return {w, ~w} ^ (32'(w) * 32'h9e3779b1);
    endfunction

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] <= init_word(16'(i));
        end
    end

    // burst address is line aligned, the beat picks the word
    assign req_addr = cbus_req.addr;
    assign word_idx = {req_addr[17:6], beat_q};
    assign lfsr_mid = lfsr_next(lfsr_q);
    assign ready = cbus_req.valid && !stall_q;

    always_comb begin
        cbus_resp.ready = ready;
        cbus_resp.last = ready && (beat_q == offset_t'(words_per_line - 1));
        cbus_resp.data = mem[word_idx];
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            beat_q <= '0;
            stall_q <= 1'b0;
            lfsr_q <= seed;
        end else begin
            // two bits a cycle, stall when both are set
            stall_q <= lfsr_q[0] & lfsr_mid[0];
            lfsr_q <= lfsr_next(lfsr_mid);
            if (ready) begin
                if (cbus_req.is_write) begin
                    mem[word_idx] <= cbus_req.data;
                end
                beat_q <= beat_q + 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam logic [15:0] seed = 16'd15;
    localparam int num_requests = 442;
    localparam int cycle_limit = 200 * num_requests;

    logic       clk;
    logic       resetn;
    dreq_t      dreq;
    dresp_t     dresp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    int          errors;
    int          checks;
    int          tests;
    int          cycle;
    logic [15:0] lfsr_q;
    logic        checking;

    // shadow memory, keyed by word address
    word_t shadow [int unsigned];

    // hit and miss model
    tag_t mtag [num_sets][num_ways];
    logic mvalid [num_sets][num_ways];
    logic mlru [num_sets];

    // what the compare process expects after an accepted request
    logic  took_last;
    logic  took_read;
    word_t took_expect;

    logic first_hit;
    logic saw_bus;
    logic saw_wb;

    dcache u_dcache (
        .clk       (clk),
        .resetn    (resetn),
        .dreq      (dreq),
        .dresp     (dresp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    mem_model u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic word_t init_word(input logic [15:0] w);
        return {w, ~w} ^ (32'(w) * 32'h9e3779b1);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int off);
        return (32'(tag) << 13) | (32'(set) << 6) | (32'(off) << 2);
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        int unsigned k;
        k = 32'(addr[17:2]);
        if (shadow.exists(k)) begin
            return shadow[k];
        end
        return init_word(addr[17:2]);
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input strobe_t strobe, input word_t data);
        word_t cur;
        cur = expected_word(addr);
        for (int i = 0; i < bytes_per_word; i++) begin
            if (strobe[i]) begin
                cur[8*i +: 8] = data[8*i +: 8];
            end
        end
        shadow[32'(addr[17:2])] = cur;
    endtask

    function automatic logic predict_hit(input addr_t a);
        logic h;
        h = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (mvalid[a.index][w] && (mtag[a.index][w] == a.tag)) begin
                h = 1'b1;
            end
        end
        return h;
    endfunction

    // victim is the way not used last, and the refilled way becomes the last used
    task automatic model_touch(input addr_t a);
        int w;
        if (mvalid[a.index][0] && (mtag[a.index][0] == a.tag)) begin
            mlru[a.index] = 1'b0;
        end else if (mvalid[a.index][1] && (mtag[a.index][1] == a.tag)) begin
            mlru[a.index] = 1'b1;
        end else begin
            w = mlru[a.index] ? 0 : 1;
            mtag[a.index][w] = a.tag;
            mvalid[a.index][w] = 1'b1;
            mlru[a.index] = (w == 1);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic access(input logic [31:0] addr, input strobe_t strobe, input word_t data);
        logic predicted;
        logic accepted;
        int   waited;
        predicted = predict_hit(addr);
        accepted = 1'b0;
        waited = 0;
        saw_bus = 1'b0;
        saw_wb = 1'b0;
        @(negedge clk);
        dreq.valid = 1'b1;
        dreq.addr = addr;
        dreq.strobe = strobe;
        dreq.data = data;
        while (!accepted) begin
            #2;
            if (dresp.addr_ok) begin
                accepted = 1'b1;
            end else begin
                saw_bus = saw_bus | cbus_req.valid;
                saw_wb = saw_wb | (cbus_req.valid & cbus_req.is_write);
                @(negedge clk);
                waited++;
            end
        end
        first_hit = (waited == 0);
        check_value("addr_ok in request cycle", 32'(first_hit), 32'(predicted));
        took_read = (strobe == '0);
        took_expect = expected_word(addr);
        took_last = 1'b1;
        if (strobe != '0) begin
            shadow_write(addr, strobe, data);
        end
        model_touch(addr);
        @(negedge clk);
        dreq.valid = 1'b0;
        #1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d mismatches", tests, name, errors - errors_before);
        end
    endtask

    // data_ok must follow each accepted request by one cycle
    always @(negedge clk) begin
        if (checking) begin
            check_value("dresp.data_ok", 32'(dresp.data_ok), 32'(took_last));
            if (took_last && took_read) begin
                check_value("dresp.data", dresp.data, took_expect);
            end
            took_last = 1'b0;
        end
    end

    initial begin
        cycle = 0;
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          e0;
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
        logic [31:0] r_set;
        logic [31:0] r_tag;
        logic [31:0] r_off;
        logic [31:0] r_wr;
        logic [31:0] r_st;
        logic [31:0] r_data;
        strobe_t     st;
        dreq = '0;
        resetn = 1'b1;
        checking = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        lfsr_q = seed;
        took_last = 1'b0;
        took_read = 1'b0;
        took_expect = '0;
        for (int s = 0; s < num_sets; s++) begin
            mlru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                mvalid[s][w] = 1'b0;
                mtag[s][w] = '0;
            end
        end
        repeat (5) @(negedge clk);
        resetn = 1'b0;
        #2;
        checking = 1'b1;

        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            #2;
            check_value("dresp.addr_ok", 32'(dresp.addr_ok), 32'd0);
            check_value("dresp.data_ok", 32'(dresp.data_ok), 32'd0);
            check_value("cbus_req.valid", 32'(cbus_req.valid), 32'd0);
        end
        report_test("idle after reset", e0);

        e0 = errors;
        a_addr = make_addr(2, 10, 5);
        access(a_addr, 4'h0, '0);
        check_value("cbus_req.valid on miss", 32'(saw_bus), 32'd1);
        access(a_addr, 4'h0, '0);
        check_value("hit on repeat", 32'(first_hit), 32'd1);
        report_test("read miss then hit", e0);

        e0 = errors;
        a_addr = make_addr(1, 5, 3);
        for (int s = 1; s < 16; s++) begin
            take_bits(32, r_data);
            access(a_addr, strobe_t'(s), r_data);
            access(a_addr, 4'h0, '0);
        end
        report_test("byte strobes", e0);

        // A fills way 1, B way 0, C then evicts the dirty A
        e0 = errors;
        a_addr = make_addr(4, 20, 7);
        b_addr = make_addr(5, 20, 7);
        c_addr = make_addr(6, 20, 7);
        take_bits(32, r_data);
        access(a_addr, 4'hf, r_data);
        access(b_addr, 4'h0, '0);
        access(c_addr, 4'h0, '0);
        check_value("writeback burst seen", 32'(saw_wb), 32'd1);
        access(a_addr, 4'h0, '0);
        report_test("dirty eviction", e0);

        e0 = errors;
        a_addr = make_addr(4, 40, 1);
        b_addr = make_addr(5, 40, 1);
        c_addr = make_addr(6, 40, 1);
        access(a_addr, 4'h0, '0);
        access(b_addr, 4'h0, '0);
        access(a_addr, 4'h0, '0);
        access(c_addr, 4'h0, '0);
        access(a_addr, 4'h0, '0);
        check_value("A kept by LRU", 32'(first_hit), 32'd1);
        access(b_addr, 4'h0, '0);
        check_value("B evicted by LRU", 32'(first_hit), 32'd0);
        report_test("LRU order", e0);

        e0 = errors;
        for (int i = 0; i < 400; i++) begin
            take_bits(3, r_set);
            take_bits(2, r_tag);
            take_bits(4, r_off);
            take_bits(1, r_wr);
            take_bits(4, r_st);
            take_bits(32, r_data);
            st = strobe_t'(r_st);
            if (r_wr == 0) begin
                st = 4'h0;
            end else if (st == 4'h0) begin
                st = 4'hf;
            end
            access(make_addr(8 + r_tag, 64 + r_set, r_off), st, r_data);
        end
        report_test("random traffic", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dcache.f ====
common/dcache_pkg.sv
dcache/dcache_lookup.sv
dcache/dcache_data_ram.sv
dcache/dcache_miss_ctrl.sv
src/cbus_port.sv
src/dcache.sv
tests/mem_model.sv
tests/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f dcache.f -o sim_dcache
./obj_dir/sim_dcache > sim.log 2>&1
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
